/* sim.f */
+incdir+design
design/bus_pkg.sv
design/fetch_pkg.sv
design/prefetch_buffer.sv
design/compressed_decoder.sv
design/if_stage.sv
verification/tb_if_stage.sv

/* verification/tb_if_stage.sv */
/*
 * testbench for the instruction fetch stage
 * memory responder, random redirects and stalls, reference model and checks
 */
`include "if_cfg.svh"

module tb_if_stage
  import bus_pkg::*;
  import fetch_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NUM_CYCLES  = 3000;
  localparam int unsigned CYCLE_LIMIT = 20 * NUM_CYCLES;
  localparam logic [31:0] BOOT_ADDR   = 32'h1C00_8000;
  // word index inside the 1 KiB image that answers with err
  localparam logic [7:0]  ERR_WORD    = 8'h24;

  logic        clk_i, rst_ni;
  logic [31:0] boot_addr, csr_mepc, csr_depc, jump_target;
  logic        req, pc_set, instr_valid_clear, id_in_ready;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  exc_cause_e  exc_cause;
  instr_req_t  bus_req;
  instr_rsp_t  bus_rsp;
  logic        instr_valid_id, instr_new_id, if_busy, perf_imiss;
  if_id_t      if_id;
  logic [31:0] pc_if, csr_mtvec;

  // 256 words, addresses alias on bits 9:2
  logic [31:0] mem [256];
  logic [31:0] rsp_addr_q [$];
  int unsigned rsp_due_q [$];
  int unsigned last_due  = 0;
  int unsigned cycle_cnt = 0;

  // reference model state
  logic [31:0] exp_pc;
  logic        exp_valid, started, got_new;
  logic        prev_ready, prev_pcset, prev_clear, prev_imiss;
  if_id_t      held;
  int unsigned n_loaded;

  if_stage UUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr),
    .req_i               (req),
    .bus_req_o           (bus_req),
    .bus_rsp_i           (bus_rsp),
    .instr_valid_id_o    (instr_valid_id),
    .instr_new_id_o      (instr_new_id),
    .if_id_o             (if_id),
    .pc_if_o             (pc_if),
    .instr_valid_clear_i (instr_valid_clear),
    .pc_set_i            (pc_set),
    .csr_mepc_i          (csr_mepc),
    .csr_depc_i          (csr_depc),
    .pc_mux_i            (pc_mux),
    .exc_pc_mux_i        (exc_pc_mux),
    .exc_cause_i         (exc_cause),
    .jump_target_i       (jump_target),
    .csr_mtvec_o         (csr_mtvec),
    .id_in_ready_i       (id_in_ready),
    .if_busy_o           (if_busy),
    .perf_imiss_o        (perf_imiss)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_if_id(input if_id_t got, input if_id_t exp, input string what);
    if_id_t g;
    if_id_t e;
    g = got;
    e = exp;
    // upper half of an unexpanded compressed word carries no meaning
    if (e.is_compressed && e.illegal_c) begin
      g.rdata[31:16] = '0;
      e.rdata[31:16] = '0;
    end
    if (g !== e) begin
      $display("CHECK FAILED at %0t: %s pc %h got %h exp %h", $time, what, exp.pc, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h exp %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b exp %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] half_at(input logic [31:0] a);
    logic [31:0] w;
    w = mem[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic err_at(input logic [31:0] a);
    return a[9:2] == ERR_WORD;
  endfunction

  // subset expander written from the C extension tables
  function automatic logic [31:0] expand_compressed(input logic [15:0] c, output logic illegal);
    logic [11:0] imm;
    logic [20:0] off;
    logic [4:0]  rd, rs2;
    logic [31:0] ins;
    rd      = c[11:7];
    rs2     = c[6:2];
    imm     = {{6{c[12]}}, c[12], c[6:2]};
    // c.j offset[11|4|9:8|10|6|7|3:1|5] lives in c[12:2]
    off     = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    illegal = 1'b0;
    ins     = {16'h0000, c};
    case ({c[1:0], c[15:13]})
      5'b01_000: ins = {imm, rd, 3'b000, rd, 7'h13};
      5'b01_010: ins = {imm, 5'd0, 3'b000, rd, 7'h13};
      5'b01_101: ins = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
      5'b10_100: begin
        if (rs2 != 5'd0) begin
          ins = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, 7'h33};
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    return ins;
  endfunction

  function automatic if_id_t expected_entry(input logic [31:0] pc);
    if_id_t      e;
    logic [15:0] lo;
    logic        ill;
    lo              = half_at(pc);
    e.pc            = pc;
    e.rdata_c       = lo;
    e.is_compressed = lo[1:0] != 2'b11;
    if (e.is_compressed) begin
      e.rdata     = expand_compressed(lo, ill);
      e.illegal_c = ill;
      e.fetch_err = err_at(pc);
    end else begin
      // may straddle two words
      e.rdata     = {half_at(pc + 32'd2), lo};
      e.illegal_c = 1'b0;
      e.fetch_err = err_at(pc) | err_at(pc + 32'd2);
    end
    return e;
  endfunction

  function automatic logic [31:0] redirect_target();
    case (pc_mux)
      PC_JUMP: return jump_target;
      PC_ERET: return csr_mepc;
      PC_DRET: return csr_depc;
      PC_EXC: begin
        case (exc_pc_mux)
          EXC_PC_EXC: return {BOOT_ADDR[31:8], 8'h00};
          EXC_PC_IRQ: return {BOOT_ADDR[31:8], 8'(exc_cause[4:0]) * 8'd4};
          EXC_PC_DBD: return `IF_DM_HALT_ADDR;
          default:    return `IF_DM_EXC_ADDR;
        endcase
      end
      default: return {BOOT_ADDR[31:8], 8'h80};
    endcase
  endfunction

  // about half compressed, most of those steered to supported forms
  task automatic fill_memory();
    logic [15:0] h;
    logic [1:0]  q;
    for (int w = 0; w < 256; w++) begin
      for (int k = 0; k < 2; k++) begin
        h = 16'($urandom);
        if ($urandom_range(0, 1) == 0) begin
          h[1:0] = 2'b11;
        end else begin
          q      = 2'($urandom_range(0, 2));
          h[1:0] = q;
          if (q == 2'b01) begin
            case ($urandom_range(0, 3))
              0: h[15:13] = 3'b000;
              1: h[15:13] = 3'b010;
              2: h[15:13] = 3'b101;
              default: ;
            endcase
          end else if (q == 2'b10 && $urandom_range(0, 3) != 0) begin
            h[15:13] = 3'b100;
          end
        end
        mem[w][16*k +: 16] = h;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory responder, in-order rvalid 1 to 3 cycles after grant
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    int unsigned due;
    bus_rsp = '0;
    wait (rst_ni);
    forever begin
      @(posedge clk_i);
      #1;
      bus_rsp.rvalid = 1'b0;
      bus_rsp.err    = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle_cnt) begin
        a = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        bus_rsp.rvalid = 1'b1;
        bus_rsp.rdata  = mem[a[9:2]];
        bus_rsp.err    = a[9:2] == ERR_WORD;
      end
      // req is a register output, stable for the whole cycle
      bus_rsp.gnt = bus_req.req && ($urandom_range(0, 2) != 0);
      if (bus_rsp.gnt) begin
        due = cycle_cnt + 1 + $urandom_range(0, 2);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(bus_req.addr);
        rsp_due_q.push_back(due);
      end
    end
  end

  // cycle limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("simulation hung, cycle limit of %0d reached", CYCLE_LIMIT);
      stop_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per cycle check and stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic random_on);
    if_id_t      e;
    int unsigned inflight;
    @(posedge clk_i);
    // reads granted before this edge and not yet answered
    inflight = rsp_due_q.size();
    #1;
    got_new = instr_new_id;
    // nothing may load in a stalled or redirected cycle
    if (prev_pcset || !prev_ready) begin
      check_flag(instr_new_id, 1'b0, "load while stalled or redirected");
    end
    // a miss is a cycle in which a ready ID got nothing
    if (prev_pcset) begin
      check_flag(prev_imiss, 1'b1, "perf_imiss on redirect");
    end else if (prev_ready) begin
      check_flag(prev_imiss, !instr_new_id, "perf_imiss");
    end
    if (instr_new_id) begin
      e = expected_entry(exp_pc);
      check_if_id(if_id, e, "if_id after load");
      held      = if_id;
      exp_pc    = exp_pc + (e.is_compressed ? 32'd2 : 32'd4);
      exp_valid = 1'b1;
      started   = 1'b1;
      n_loaded++;
    end else begin
      if (prev_clear) begin
        exp_valid = 1'b0;
      end
      if (started) begin
        check_if_id(if_id, held, "if_id hold");
      end
    end
    check_flag(instr_valid_id, exp_valid, "instr_valid_id");
    // busy while a request waits for grant or a granted read is unanswered
    check_flag(if_busy, bus_req.req || inflight != 0, "if_busy");
    check_addr(csr_mtvec, {BOOT_ADDR[31:8], 8'h01}, "csr_mtvec");
    if (started) begin
      check_addr(pc_if, exp_pc, "pc_if");
    end

    pc_set            = 1'b0;
    instr_valid_clear = 1'b0;
    id_in_ready       = 1'b1;
    if (random_on) begin
      id_in_ready       = $urandom_range(0, 3) != 0;
      instr_valid_clear = $urandom_range(0, 9) == 0;
      // redirects only once the boot fetch has delivered
      if (started && $urandom_range(0, 39) == 0) begin
        pc_set      = 1'b1;
        pc_mux      = pc_sel_e'(3'($urandom_range(0, 4)));
        exc_pc_mux  = exc_pc_sel_e'(2'($urandom_range(0, 3)));
        exc_cause   = exc_cause_e'(6'($urandom));
        jump_target = $urandom & 32'hFFFF_FFFE;
        csr_mepc    = $urandom & 32'hFFFF_FFFE;
        csr_depc    = $urandom & 32'hFFFF_FFFE;
        exp_pc      = redirect_target();
      end
    end
    prev_ready = id_in_ready;
    prev_pcset = pc_set;
    prev_clear = instr_valid_clear;
    // miss flag settles once this cycle's inputs are in
    #1;
    prev_imiss = perf_imiss;
  endtask

  initial begin
    void'($urandom(32'hf85140a9));
    rst_ni            = 1'b0;
    boot_addr         = BOOT_ADDR;
    req               = 1'b1;
    pc_set            = 1'b0;
    instr_valid_clear = 1'b0;
    id_in_ready       = 1'b1;
    pc_mux            = PC_BOOT;
    exc_pc_mux        = EXC_PC_EXC;
    exc_cause         = EXC_CAUSE_IRQ_TIMER_M;
    jump_target       = '0;
    csr_mepc          = '0;
    csr_depc          = '0;
    fill_memory();

    exp_pc     = {BOOT_ADDR[31:8], 8'h80};
    exp_valid  = 1'b0;
    started    = 1'b0;
    prev_ready = 1'b1;
    prev_pcset = 1'b0;
    prev_clear = 1'b0;
    n_loaded   = 0;

    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    // the boot branch cycle
    #1 prev_imiss = perf_imiss;

    for (int i = 0; i < NUM_CYCLES; i++) begin
      run_cycle(1'b1);
    end
    // drain with ID ready until one more instruction arrives
    got_new = 1'b0;
    while (!got_new) begin
      run_cycle(1'b0);
    end

    if (n_loaded >= 50) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("only %0d instructions were delivered", n_loaded);
      stop_run();
    end
  end

endmodule

/* design/if_stage.sv */
/*
 * instruction fetch stage top
 * pc and trap vector muxes, fetch init state, IF-ID register
 */
`include "if_cfg.svh"

module if_stage
  import bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] boot_addr_i,
  input  logic        req_i,
  output instr_req_t  bus_req_o,
  input  instr_rsp_t  bus_rsp_i,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output if_id_t      if_id_o,
  output logic [31:0] pc_if_o,
  input  logic        instr_valid_clear_i,
  input  logic        pc_set_i,
  input  logic [31:0] csr_mepc_i,
  input  logic [31:0] csr_depc_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_e  exc_cause_i,
  input  logic [31:0] jump_target_i,
  output logic [31:0] csr_mtvec_o,
  input  logic        id_in_ready_i,
  output logic        if_busy_o,
  output logic        perf_imiss_o
);

  logic         init_q, init_d;
  logic         branch, fetch_ready, fetch_valid, fetch_busy;
  logic [31:0]  fetch_addr_n, exc_pc;
  fetch_entry_t fetch_entry;
  logic [31:0]  instr_exp;
  logic         instr_is_c, instr_illegal_c;
  logic         if_id_we;
  if_id_t       if_id_d, if_id_q;
  logic         valid_q, new_q;

  ////////////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////////////

  // vectored mode, base shares the boot page
  assign csr_mtvec_o = {boot_addr_i[31:8], 8'h01};

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {boot_addr_i[31:8], 8'h00};
      // one word per interrupt line
      EXC_PC_IRQ:     exc_pc = {boot_addr_i[31:8], 1'b0, exc_cause_i[4:0], 2'b00};
      EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      PC_JUMP: fetch_addr_n = jump_target_i;
      PC_EXC:  fetch_addr_n = exc_pc;
      PC_ERET: fetch_addr_n = csr_mepc_i;
      PC_DRET: fetch_addr_n = csr_depc_i;
      default: fetch_addr_n = {boot_addr_i[31:8], 8'h80};
    endcase
  end

  prefetch_buffer u_prefetch_buffer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .branch_i  (branch),
    .addr_i    (fetch_addr_n),
    .ready_i   (fetch_ready),
    .valid_o   (fetch_valid),
    .entry_o   (fetch_entry),
    .bus_req_o (bus_req_o),
    .bus_rsp_i (bus_rsp_i),
    .busy_o    (fetch_busy)
  );

  // leave init on the first request, any pc_set redirects
  assign branch = (init_q & req_i) | pc_set_i;
  assign init_d = init_q & ~branch;

  // entries are taken only while ID accepts and no redirect is pending
  assign if_id_we    = ~init_q & fetch_valid & id_in_ready_i & ~pc_set_i;
  assign fetch_ready = if_id_we;

  assign pc_if_o      = fetch_entry.addr;
  assign if_busy_o    = fetch_busy;
  assign perf_imiss_o = ~fetch_valid | branch;

  compressed_decoder u_compressed_decoder (
    .instr_i         (fetch_entry.rdata),
    .instr_o         (instr_exp),
    .is_compressed_o (instr_is_c),
    .illegal_o       (instr_illegal_c)
  );

  ////////////////////////////////////////////////////////////////////
  // IF-ID register
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    if_id_d.rdata         = instr_exp;
    if_id_d.rdata_c       = fetch_entry.rdata[15:0];
    if_id_d.is_compressed = instr_is_c;
    if_id_d.illegal_c     = instr_illegal_c;
    if_id_d.fetch_err     = fetch_entry.err;
    if_id_d.pc            = fetch_entry.addr;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q  <= 1'b1;
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      init_q <= init_d;
      new_q  <= if_id_we;
      // a load wins over a clear in the same cycle
      if (if_id_we) begin
        valid_q <= 1'b1;
      end else if (instr_valid_clear_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (if_id_we) begin
      if_id_q <= if_id_d;
    end
  end

  assign if_id_o          = if_id_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // trap vectors assume a 256 byte aligned boot page
  boot_align_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    boot_addr_i[7:0] == 8'h00)
    else $error("boot address not 256 byte aligned");

  gnt_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_i.gnt |-> bus_req_o.req)
    else $error("grant without a request");

  addr_align_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.req |-> bus_req_o.addr[1:0] == 2'b00)
    else $error("instruction address not word aligned");

endmodule

/* design/compressed_decoder.sv */
/*
 * compressed instruction expander
 * c.addi, c.li, c.mv, c.add and c.j, everything else compressed is illegal
 */
module compressed_decoder
  import fetch_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  assign is_compressed_o = instr_i[1:0] != 2'b11;

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    unique case (instr_i[1:0])
      // quadrant 0, loads and stores are not supported
      2'b00: begin
        illegal_o = 1'b1;
      end

      // quadrant 1
      2'b01: begin
        unique case (instr_i[15:13])
          // c.addi -> addi rd, rd, imm
          3'b000: begin
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                       3'b000, instr_i[11:7], OPCODE_OP_IMM};
          end
          // c.li -> addi rd, x0, imm
          3'b010: begin
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b00000,
                       3'b000, instr_i[11:7], OPCODE_OP_IMM};
          end
          // c.j -> jal x0, offset
          // offset bits sit scrambled in [12:2]
          3'b101: begin
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                       instr_i[2], instr_i[11], instr_i[5:3], {9{instr_i[12]}},
                       5'b00000, OPCODE_JAL};
          end
          default: begin
            illegal_o = 1'b1;
          end
        endcase
      end

      // quadrant 2, only the register moves and adds
      2'b10: begin
        // rs2 of zero would be c.jr, c.jalr or c.ebreak
        if (instr_i[15:13] == 3'b100 && instr_i[6:2] != 5'b00000) begin
          if (instr_i[12]) begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0000000, instr_i[6:2], instr_i[11:7], 3'b000,
                       instr_i[11:7], OPCODE_OP};
          end else begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0000000, instr_i[6:2], 5'b00000, 3'b000,
                       instr_i[11:7], OPCODE_OP};
          end
        end else begin
          illegal_o = 1'b1;
        end
      end

      // full width instruction passes unchanged
      2'b11: begin
        instr_o = instr_i;
      end
    endcase
  end

endmodule

/* design/prefetch_buffer.sv */
/*
 * prefetch buffer
 * word reads over the instruction bus, a small word queue,
 * and realignment of instructions at halfword addresses
 */
`include "if_cfg.svh"

module prefetch_buffer
  import bus_pkg::*;
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  logic         branch_i,
  input  logic [31:0]  addr_i,
  input  logic         ready_i,
  output logic         valid_o,
  output fetch_entry_t entry_o,
  output instr_req_t   bus_req_o,
  input  instr_rsp_t   bus_rsp_i,
  output logic         busy_o
);

  localparam int unsigned DEPTH = `IF_FIFO_DEPTH;
  localparam int unsigned CW    = $clog2(DEPTH + 1);

  typedef struct packed {
    logic        err;
    logic [31:0] data;
  } word_t;

  // queue storage, index 0 is the head
  word_t         fifo_q [DEPTH];
  word_t         fifo_d [DEPTH];
  logic [CW-1:0] fifo_cnt_q, fifo_cnt_d;
  logic [CW-1:0] wr_idx;
  // reads granted and not yet returned, and how many of those to drop
  logic [CW-1:0] out_cnt_q, out_cnt_d;
  logic [CW-1:0] disc_cnt_q, disc_cnt_d;
  logic [CW:0]   fill;
  // pending bus request, stale once a branch passed it
  logic          breq_q, breq_d;
  logic [31:0]   baddr_q, baddr_d;
  logic          stale_q, stale_d;
  logic [31:0]   fetch_addr_q, fetch_addr_d;
  logic [31:0]   next_fetch;
  logic [31:0]   cur_addr_q, cur_addr_d;
  logic [15:0]   instr_lo;
  logic          instr_c;
  logic          gnt_ok, drop, push, pop, consume, new_req;

  assign gnt_ok = breq_q & bus_rsp_i.gnt;
  assign drop   = bus_rsp_i.rvalid & (disc_cnt_q != '0);
  // words arriving during a branch belong to the old stream
  assign push   = bus_rsp_i.rvalid & ~drop & ~branch_i;

  ////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////

  assign instr_lo = cur_addr_q[1] ? fifo_q[0].data[31:16] : fifo_q[0].data[15:0];
  assign instr_c  = instr_lo[1:0] != 2'b11;

  // a 32-bit instruction in the upper half needs the next word as well
  assign valid_o = (fifo_cnt_q > CW'(1)) |
                   ((fifo_cnt_q == CW'(1)) & (~cur_addr_q[1] | instr_c));

  assign entry_o.addr  = cur_addr_q;
  assign entry_o.rdata = cur_addr_q[1] ? {fifo_q[1].data[15:0], fifo_q[0].data[31:16]}
                                       : fifo_q[0].data;
  assign entry_o.err   = fifo_q[0].err | (cur_addr_q[1] & ~instr_c & fifo_q[1].err);

  assign consume = valid_o & ready_i & ~branch_i;
  // head word is finished unless a compressed instruction sat in its low half
  assign pop     = consume & (cur_addr_q[1] | ~instr_c);
  assign wr_idx  = fifo_cnt_q - CW'(pop);

  always_comb begin
    fifo_d     = fifo_q;
    fifo_cnt_d = fifo_cnt_q;
    if (branch_i) begin
      fifo_cnt_d = '0;
    end else begin
      if (pop) begin
        for (int i = 0; i < DEPTH - 1; i++) begin
          fifo_d[i] = fifo_q[i + 1];
        end
      end
      if (push) begin
        fifo_d[wr_idx] = '{err: bus_rsp_i.err, data: bus_rsp_i.rdata};
      end
      fifo_cnt_d = fifo_cnt_q + CW'(push) - CW'(pop);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    out_cnt_d = out_cnt_q + CW'(gnt_ok) - CW'(bus_rsp_i.rvalid);
    // a branch turns everything still in flight into discards
    if (branch_i) begin
      disc_cnt_d = out_cnt_d;
    end else begin
      disc_cnt_d = disc_cnt_q + CW'(gnt_ok & stale_q) - CW'(drop);
    end

    // room counts queued words and every read in flight
    fill       = {1'b0, fifo_cnt_d} + {1'b0, out_cnt_d};
    next_fetch = branch_i ? {addr_i[31:2], 2'b00} : fetch_addr_q;
    new_req    = (~breq_q | bus_rsp_i.gnt) & req_i & (fill < (CW + 1)'(DEPTH));

    // an ungranted request keeps its address
    breq_d       = breq_q & ~bus_rsp_i.gnt;
    baddr_d      = baddr_q;
    fetch_addr_d = next_fetch;
    if (new_req) begin
      breq_d       = 1'b1;
      baddr_d      = next_fetch;
      fetch_addr_d = next_fetch + 32'd4;
    end
    stale_d = (branch_i | stale_q) & breq_q & ~bus_rsp_i.gnt;

    cur_addr_d = cur_addr_q;
    if (branch_i) begin
      cur_addr_d = {addr_i[31:1], 1'b0};
    end else if (consume) begin
      cur_addr_d = cur_addr_q + (instr_c ? 32'd2 : 32'd4);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_cnt_q   <= '0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
      breq_q       <= 1'b0;
      baddr_q      <= '0;
      stale_q      <= 1'b0;
      fetch_addr_q <= '0;
      cur_addr_q   <= '0;
    end else begin
      fifo_cnt_q   <= fifo_cnt_d;
      out_cnt_q    <= out_cnt_d;
      disc_cnt_q   <= disc_cnt_d;
      breq_q       <= breq_d;
      baddr_q      <= baddr_d;
      stale_q      <= stale_d;
      fetch_addr_q <= fetch_addr_d;
      cur_addr_q   <= cur_addr_d;
    end
  end

  // word storage
  always_ff @(posedge clk_i) begin
    fifo_q <= fifo_d;
  end

  assign bus_req_o.req  = breq_q;
  assign bus_req_o.addr = baddr_q;
  assign busy_o         = breq_q | (out_cnt_q != '0);

  // request and address hold across wait cycles
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o.req && !bus_rsp_i.gnt |=> bus_req_o.req && $stable(bus_req_o.addr))
    else $error("instruction request changed before grant");

  // each response answers an earlier grant
  rvalid_out_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_i.rvalid |-> out_cnt_q != '0)
    else $error("rvalid without an outstanding read");

endmodule

/* design/fetch_pkg.sv */
/*
 * fetch stage types
 * pc and exception vector selects, exception cause, fetch entry and IF-ID contents
 */
package fetch_pkg;

  // major opcodes produced by the compressed expander
  localparam logic [6:0] OPCODE_OP_IMM = 7'h13;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap vector source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // bit 5 set for interrupts, low bits carry the id
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = {1'b0, 5'd0},
    EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1},
    EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2},
    EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3},
    EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11},
    EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3},
    EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7},
    EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11},
    EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31}
  } exc_cause_e;

  // prefetch buffer output, upper rdata half is junk for compressed
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

  // IF-ID register
  typedef struct packed {
    logic [31:0] rdata;
    logic [15:0] rdata_c;
    logic        is_compressed;
    logic        illegal_c;
    logic        fetch_err;
    logic [31:0] pc;
  } if_id_t;

endpackage

/* design/bus_pkg.sv */
/*
 * instruction bus types
 * request from the fetch stage and response from memory
 */
package bus_pkg;

  ////////////////////////////////////////////////////////////////////
  // instruction bus
  ////////////////////////////////////////////////////////////////////

  // stage to bus, held until gnt
  typedef struct packed {
    logic        req;
    // always word aligned
    logic [31:0] addr;
  } instr_req_t;

  // bus to stage
  typedef struct packed {
    logic        gnt;
    // one rvalid per grant, in order
    logic        rvalid;
    logic [31:0] rdata;
    // only meaningful together with rvalid
    logic        err;
  } instr_rsp_t;

endpackage

/* design/if_cfg.svh */
/*
 * configuration macros for the instruction fetch stage
 * debug entry addresses and prefetch queue depth
 */
`ifndef IF_CFG_SVH
`define IF_CFG_SVH

// debug module halt entry point
`define IF_DM_HALT_ADDR 32'h1A110800

// debug module exception entry point
`define IF_DM_EXC_ADDR 32'h1A110808

// fetched words the prefetch queue may hold, reads in flight included
`define IF_FIFO_DEPTH 3

`endif
